//--- include/dsp_consts.svh
`ifndef DSP_CONSTS_SVH
`define DSP_CONSTS_SVH

// Dual-lane operand and coefficient width
`define DSP_HALF_W 18
// Dual-lane pre-adder sum, one carry bit wider
`define DSP_SUM_W 19
// Dual-lane product, also the packed operand word of one lane
`define DSP_LANE_PROD_W 37

// 27x27 mode
`define DSP_WIDE_OP_W 26
`define DSP_WIDE_W 27
`define DSP_WIDE_PROD_W 54

// Width of each operand and coefficient input port
`define DSP_IN_W 36

// Accumulator and final result
`define DSP_ACC_W 64
// Raw product field, also resultb
`define DSP_RAW_W 36

// Coefficient bank geometry
`define DSP_BANK_DEPTH 8
`define DSP_BANK_AW 3

`endif

//--- design/dsp_pkg.sv
`include "dsp_consts.svh"

package dsp_pkg;

	// One mode bit, 18x19 lanes or one 27x27 multiply
	typedef enum logic {
		MODE_DUAL = 1'b0,
		MODE_WIDE = 1'b1
	} dsp_mode_t;

	// Control word, travels with its item through every stage
	typedef struct packed {
		dsp_mode_t mode;
		logic      sub;        // Low minus high in dual mode
		logic      negate;     // Two's complement of post result
		logic      accumulate;
		logic      loadconst;
		logic      result_sel; // 1 accumulate path, 0 raw products
	} dsp_ctrl_t;

	// Dual mode: {high product, low product}
	// Wide mode: product in the low 54 bits
	typedef logic [2*`DSP_LANE_PROD_W-1:0] product_t;

endpackage

//--- design/coeff_bank.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module coeff_bank (
	input  logic                    clk,
	input  logic                    we,
	input  logic                    sel,     // 1 writes memory a
	input  logic [`DSP_BANK_AW-1:0] waddr,
	input  logic [`DSP_HALF_W-1:0]  wdata,
	input  logic [`DSP_BANK_AW-1:0] raddr_a,
	input  logic [`DSP_BANK_AW-1:0] raddr_b,
	output logic [`DSP_HALF_W-1:0]  rdata_a,
	output logic [`DSP_HALF_W-1:0]  rdata_b
);

	logic [`DSP_HALF_W-1:0] mem_a [`DSP_BANK_DEPTH];
	logic [`DSP_HALF_W-1:0] mem_b [`DSP_BANK_DEPTH];

	// Only one memory written per cycle
	always_ff @(posedge clk) begin
		if (we && sel) begin
			mem_a[waddr] <= wdata;
		end
		if (we && !sel) begin
			mem_b[waddr] <= wdata;
		end
	end

	// Read addresses come registered from the input stage
	assign rdata_a = mem_a[raddr_a];
	assign rdata_b = mem_b[raddr_b];

endmodule

//--- design/operand_select.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module operand_select import dsp_pkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  dsp_ctrl_t                   ctrl,
	input  logic                        internal_coeff_a,
	input  logic                        internal_coeff_b,
	input  logic [`DSP_IN_W-1:0]        pre_in1,
	input  logic [`DSP_IN_W-1:0]        pre_in2,
	input  logic [`DSP_IN_W-1:0]        coef_in,
	input  logic [`DSP_BANK_AW-1:0]     coef_addr_a,
	input  logic [`DSP_BANK_AW-1:0]     coef_addr_b,
	input  logic [`DSP_HALF_W-1:0]      bank_data_a,
	input  logic [`DSP_HALF_W-1:0]      bank_data_b,
	output logic [`DSP_BANK_AW-1:0]     bank_raddr_a,
	output logic [`DSP_BANK_AW-1:0]     bank_raddr_b,
	output logic [`DSP_LANE_PROD_W-1:0] op_x,
	output logic [`DSP_LANE_PROD_W-1:0] op_y,
	output dsp_ctrl_t                   op_ctrl
);

	dsp_ctrl_t             ctrl_q;
	logic                  int_a_q;
	logic                  int_b_q;
	logic [`DSP_IN_W-1:0]  in1_q;
	logic [`DSP_IN_W-1:0]  in2_q;
	logic [`DSP_IN_W-1:0]  coef_q;

	logic [`DSP_SUM_W-1:0]  sum_lo;
	logic [`DSP_SUM_W-1:0]  sum_hi;
	logic [`DSP_WIDE_W-1:0] sum_wide;
	logic [`DSP_HALF_W-1:0] coef_lo;
	logic [`DSP_HALF_W-1:0] coef_hi;
	logic [`DSP_WIDE_W-1:0] coef_wide;

	logic [`DSP_LANE_PROD_W-1:0] x_next;
	logic [`DSP_LANE_PROD_W-1:0] y_next;

	// Stage 1, capture the item
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_q       <= '0;
			int_a_q      <= 1'b0;
			int_b_q      <= 1'b0;
			in1_q        <= '0;
			in2_q        <= '0;
			coef_q       <= '0;
			bank_raddr_a <= '0;
			bank_raddr_b <= '0;
		end else begin
			ctrl_q       <= ctrl;
			int_a_q      <= internal_coeff_a;
			int_b_q      <= internal_coeff_b;
			in1_q        <= pre_in1;
			in2_q        <= pre_in2;
			coef_q       <= coef_in;
			bank_raddr_a <= coef_addr_a;
			bank_raddr_b <= coef_addr_b;
		end
	end

	// Pre-adders, one carry bit of growth
	assign sum_lo = {1'b0, in1_q[`DSP_HALF_W-1:0]} + {1'b0, in2_q[`DSP_HALF_W-1:0]};
	assign sum_hi = {1'b0, in1_q[`DSP_IN_W-1:`DSP_HALF_W]}
		+ {1'b0, in2_q[`DSP_IN_W-1:`DSP_HALF_W]};
	assign sum_wide = {1'b0, in1_q[`DSP_WIDE_OP_W-1:0]} + {1'b0, in2_q[`DSP_WIDE_OP_W-1:0]};

	assign coef_lo = int_a_q ? bank_data_a : coef_q[`DSP_HALF_W-1:0];
	assign coef_hi = int_b_q ? bank_data_b : coef_q[`DSP_IN_W-1:`DSP_HALF_W];
	// Wide bank coefficient spans both memories, 9 bits of b on top
	assign coef_wide = int_a_q ? {bank_data_b[`DSP_WIDE_W-`DSP_HALF_W-1:0], bank_data_a}
		: coef_q[`DSP_WIDE_W-1:0];

	// Dual mode packs each lane as {coefficient, sum}
	always_comb begin
		x_next = '0;
		y_next = '0;
		if (ctrl_q.mode == MODE_WIDE) begin
			x_next[`DSP_WIDE_W-1:0] = sum_wide;
			y_next[`DSP_WIDE_W-1:0] = coef_wide;
		end else begin
			x_next = {coef_lo, sum_lo}; // Low lane
			y_next = {coef_hi, sum_hi}; // High lane
		end
	end

	// Stage 2, multiplier operands
	always_ff @(posedge clk) begin
		if (reset) begin
			op_x    <= '0;
			op_y    <= '0;
			op_ctrl <= '0;
		end else begin
			op_x    <= x_next;
			op_y    <= y_next;
			op_ctrl <= ctrl_q;
		end
	end

endmodule

//--- design/dual_multiplier.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dual_multiplier import dsp_pkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`DSP_LANE_PROD_W-1:0] op_x,
	input  logic [`DSP_LANE_PROD_W-1:0] op_y,
	input  dsp_ctrl_t                   op_ctrl,
	output product_t                    product,
	output dsp_ctrl_t                   prod_ctrl
);

	logic [`DSP_LANE_PROD_W-1:0] prod_lo;
	logic [`DSP_LANE_PROD_W-1:0] prod_hi;
	logic [`DSP_WIDE_PROD_W-1:0] prod_wide;
	product_t                    prod_next;

	// 19x18 per lane, sum in the low bits of each operand word
	assign prod_lo = op_x[`DSP_SUM_W-1:0] * op_x[`DSP_LANE_PROD_W-1:`DSP_SUM_W];
	assign prod_hi = op_y[`DSP_SUM_W-1:0] * op_y[`DSP_LANE_PROD_W-1:`DSP_SUM_W];

	// 27x27 single product
	assign prod_wide = op_x[`DSP_WIDE_W-1:0] * op_y[`DSP_WIDE_W-1:0];

	always_comb begin
		prod_next = '0;
		if (op_ctrl.mode == MODE_WIDE) begin
			prod_next[`DSP_WIDE_PROD_W-1:0] = prod_wide;
		end else begin
			prod_next = {prod_hi, prod_lo};
		end
	end

	// Stage 3
	always_ff @(posedge clk) begin
		if (reset) begin
			product   <= '0;
			prod_ctrl <= '0;
		end else begin
			product   <= prod_next;
			prod_ctrl <= op_ctrl;
		end
	end

endmodule

//--- design/post_accumulate.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module post_accumulate import dsp_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  product_t              product,
	input  dsp_ctrl_t             prod_ctrl,
	input  logic [`DSP_ACC_W-1:0] chainin,
	input  logic [`DSP_ACC_W-1:0] constant,
	output logic [`DSP_ACC_W-1:0] resulta,
	output logic [`DSP_RAW_W-1:0] resultb,
	output logic [`DSP_ACC_W-1:0] chainout
);

	localparam int OUT_W = `DSP_RAW_W + `DSP_ACC_W;
	localparam int LANE_W = `DSP_LANE_PROD_W;

	logic [`DSP_ACC_W-1:0] lo_ext;
	logic [`DSP_ACC_W-1:0] hi_ext;
	logic [`DSP_ACC_W-1:0] wide_ext;
	logic [`DSP_ACC_W-1:0] post_val;
	logic [`DSP_ACC_W-1:0] neg_val;

	logic [`DSP_ACC_W-1:0] neg_q;
	product_t              raw_q;
	dsp_ctrl_t             ctrl_q;

	logic [`DSP_ACC_W-1:0] final_val;
	logic [OUT_W-1:0]      out_next;
	logic [OUT_W-1:0]      out_q;
	logic [`DSP_ACC_W-1:0] acc_q;

	// Everything below is modulo 2^64 on zero-extended products
	assign lo_ext = {{(`DSP_ACC_W-LANE_W){1'b0}}, product[LANE_W-1:0]};
	assign hi_ext = {{(`DSP_ACC_W-LANE_W){1'b0}}, product[2*LANE_W-1:LANE_W]};
	assign wide_ext = {{(`DSP_ACC_W-`DSP_WIDE_PROD_W){1'b0}}, product[`DSP_WIDE_PROD_W-1:0]};

	always_comb begin
		if (prod_ctrl.mode == MODE_WIDE) begin
			post_val = wide_ext; // sub has no meaning here
		end else if (prod_ctrl.sub) begin
			post_val = lo_ext - hi_ext;
		end else begin
			post_val = lo_ext + hi_ext;
		end
	end

	assign neg_val = prod_ctrl.negate ? -post_val : post_val;

	// Stage 4, keep the raw products for the bypass
	always_ff @(posedge clk) begin
		if (reset) begin
			neg_q  <= '0;
			raw_q  <= '0;
			ctrl_q <= '0;
		end else begin
			neg_q  <= neg_val;
			raw_q  <= product;
			ctrl_q <= prod_ctrl;
		end
	end

	// Priority: accumulate, then constant, then chain add
	always_comb begin
		if (ctrl_q.accumulate) begin
			final_val = neg_q + acc_q;
		end else if (ctrl_q.loadconst) begin
			final_val = constant;
		end else if (ctrl_q.negate) begin
			final_val = neg_q + chainin;
		end else begin
			final_val = neg_q;
		end
	end

	// Raw form is {high lane low bits, zeros, low lane low bits}
	always_comb begin
		if (ctrl_q.result_sel) begin
			out_next = {{`DSP_RAW_W{1'b0}}, final_val};
		end else begin
			out_next = {raw_q[LANE_W+`DSP_RAW_W-1:LANE_W],
				{(`DSP_ACC_W-`DSP_RAW_W){1'b0}},
				raw_q[`DSP_RAW_W-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_q <= '0;
			acc_q <= '0;
		end else begin
			out_q <= out_next;
			acc_q <= out_next[`DSP_ACC_W-1:0]; // Follows the output every cycle
		end
	end

	assign resulta  = out_q[`DSP_ACC_W-1:0];
	assign resultb  = out_q[OUT_W-1:`DSP_ACC_W];
	assign chainout = out_q[`DSP_ACC_W-1:0];

endmodule

//--- design/dsp_slice_top.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dsp_slice_top import dsp_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    mode,       // 0 dual 18x19, 1 single 27x27
	input  logic                    sub,
	input  logic                    negate,
	input  logic                    accumulate,
	input  logic                    loadconst,
	input  logic                    result_sel,
	input  logic                    internal_coeff_a,
	input  logic                    internal_coeff_b,
	input  logic [`DSP_IN_W-1:0]    pre_in1,
	input  logic [`DSP_IN_W-1:0]    pre_in2,
	input  logic [`DSP_IN_W-1:0]    coef_in,
	input  logic [`DSP_BANK_AW-1:0] coef_addr_a,
	input  logic [`DSP_BANK_AW-1:0] coef_addr_b,
	input  logic                    bank_we,
	input  logic                    bank_sel,
	input  logic [`DSP_BANK_AW-1:0] bank_addr,
	input  logic [`DSP_HALF_W-1:0]  bank_data,
	input  logic [`DSP_ACC_W-1:0]   chainin,
	input  logic [`DSP_ACC_W-1:0]   constant,
	output logic [`DSP_ACC_W-1:0]   resulta,
	output logic [`DSP_RAW_W-1:0]   resultb,
	output logic [`DSP_ACC_W-1:0]   chainout
);

	dsp_ctrl_t                   ctrl;
	dsp_ctrl_t                   op_ctrl;
	dsp_ctrl_t                   prod_ctrl;
	logic [`DSP_BANK_AW-1:0]     bank_raddr_a;
	logic [`DSP_BANK_AW-1:0]     bank_raddr_b;
	logic [`DSP_HALF_W-1:0]      bank_rdata_a;
	logic [`DSP_HALF_W-1:0]      bank_rdata_b;
	logic [`DSP_LANE_PROD_W-1:0] op_x;
	logic [`DSP_LANE_PROD_W-1:0] op_y;
	product_t                    product;

	assign ctrl.mode       = dsp_mode_t'(mode);
	assign ctrl.sub        = sub;
	assign ctrl.negate     = negate;
	assign ctrl.accumulate = accumulate;
	assign ctrl.loadconst  = loadconst;
	assign ctrl.result_sel = result_sel;

	// Coefficient memories sit beside the input stage
	coeff_bank u_bank (
		.clk(clk), .we(bank_we), .sel(bank_sel), .waddr(bank_addr), .wdata(bank_data),
		.raddr_a(bank_raddr_a), .raddr_b(bank_raddr_b),
		.rdata_a(bank_rdata_a), .rdata_b(bank_rdata_b)
	);

	operand_select u_operand_select (
		.clk(clk), .reset(reset), .ctrl(ctrl),
		.internal_coeff_a(internal_coeff_a), .internal_coeff_b(internal_coeff_b),
		.pre_in1(pre_in1), .pre_in2(pre_in2), .coef_in(coef_in),
		.coef_addr_a(coef_addr_a), .coef_addr_b(coef_addr_b),
		.bank_data_a(bank_rdata_a), .bank_data_b(bank_rdata_b),
		.bank_raddr_a(bank_raddr_a), .bank_raddr_b(bank_raddr_b),
		.op_x(op_x), .op_y(op_y), .op_ctrl(op_ctrl)
	);

	dual_multiplier u_multiplier (
		.clk(clk), .reset(reset), .op_x(op_x), .op_y(op_y), .op_ctrl(op_ctrl),
		.product(product), .prod_ctrl(prod_ctrl)
	);

	post_accumulate u_post (
		.clk(clk), .reset(reset), .product(product), .prod_ctrl(prod_ctrl),
		.chainin(chainin), .constant(constant),
		.resulta(resulta), .resultb(resultb), .chainout(chainout)
	);

endmodule

//--- sim/tb_dsp_slice.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module tb_dsp_slice import dsp_pkg::*; ();

	localparam int N_ADDSUB = 24;
	localparam int N_CHAIN  = 8;  // Items in each of two chain rounds
	localparam int N_WIDE   = 16;
	localparam int N_BANK   = 8;  // Items per mode after the writes
	localparam int N_ACC    = 11;
	localparam int N_RAW    = 12;
	localparam int DRAIN    = 6;
	localparam int TEST_CYCLES = 3 + (N_ADDSUB + 2) + 2 * N_CHAIN + (N_WIDE + 1)
		+ (2 << `DSP_BANK_AW) + 2 * N_BANK + (N_ACC + 1) + N_RAW + 7 * DRAIN;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    mode;
	logic                    sub;
	logic                    negate;
	logic                    accumulate;
	logic                    loadconst;
	logic                    result_sel;
	logic                    internal_coeff_a;
	logic                    internal_coeff_b;
	logic [`DSP_IN_W-1:0]    pre_in1;
	logic [`DSP_IN_W-1:0]    pre_in2;
	logic [`DSP_IN_W-1:0]    coef_in;
	logic [`DSP_BANK_AW-1:0] coef_addr_a;
	logic [`DSP_BANK_AW-1:0] coef_addr_b;
	logic                    bank_we;
	logic                    bank_sel;
	logic [`DSP_BANK_AW-1:0] bank_addr;
	logic [`DSP_HALF_W-1:0]  bank_data;
	logic [`DSP_ACC_W-1:0]   chainin;
	logic [`DSP_ACC_W-1:0]   constant;
	logic [`DSP_ACC_W-1:0]   resulta;
	logic [`DSP_RAW_W-1:0]   resultb;
	logic [`DSP_ACC_W-1:0]   chainout;

	// Reference model state
	logic [`DSP_HALF_W-1:0] bank_a_model [1 << `DSP_BANK_AW];
	logic [`DSP_HALF_W-1:0] bank_b_model [1 << `DSP_BANK_AW];
	logic [`DSP_ACC_W-1:0]  model_acc = '0;
	logic [`DSP_ACC_W-1:0]  exp_a_q [$];
	logic [`DSP_RAW_W-1:0]  exp_b_q [$];
	int                     due_q [$];

	int          cycle_cnt = 0;
	int          check_cnt = 0;
	int          error_cnt = 0;
	logic [15:0] lfsr = 16'd49603;

	dsp_slice_top u_dut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Summary: %0d checks, %0d mismatches", check_cnt, error_cnt);
			$display("Test failed");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] val;
		logic        bit_out;
		val = '0;
		for (int i = 0; i < n; i++) begin
			bit_out = lfsr[0];
			lfsr = {1'b0, lfsr[15:1]} ^ (bit_out ? 16'hB400 : 16'h0000);
			val = {val[62:0], bit_out};
		end
		return val;
	endfunction

	task automatic drive_idle();
		mode             = 1'b0;
		sub              = 1'b0;
		negate           = 1'b0;
		accumulate       = 1'b0;
		loadconst        = 1'b0;
		result_sel       = 1'b0;
		internal_coeff_a = 1'b0;
		internal_coeff_b = 1'b0;
		pre_in1          = '0;
		pre_in2          = '0;
		coef_in          = '0;
		coef_addr_a      = '0;
		coef_addr_b      = '0;
		bank_we          = 1'b0;
		bank_sel         = 1'b0;
		bank_addr        = '0;
		bank_data        = '0;
	endtask

	// Compare the oldest pending item once its result is due
	task automatic check_due();
		if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
			check_cnt++;
			if (resulta !== exp_a_q[0]) begin
				error_cnt++;
				$display("MISMATCH resulta: got %h expected %h", resulta, exp_a_q[0]);
			end
			if (resultb !== exp_b_q[0]) begin
				error_cnt++;
				$display("MISMATCH resultb: got %h expected %h", resultb, exp_b_q[0]);
			end
			if (chainout !== exp_a_q[0]) begin
				error_cnt++;
				$display("MISMATCH chainout: got %h expected %h", chainout, exp_a_q[0]);
			end
			void'(due_q.pop_front());
			void'(exp_a_q.pop_front());
			void'(exp_b_q.pop_front());
		end
	endtask

	task automatic issue_item(
		input logic m, input logic s, input logic neg, input logic acc, input logic ld,
		input logic rsel, input logic ia, input logic ib,
		input logic [`DSP_IN_W-1:0] in1, input logic [`DSP_IN_W-1:0] in2,
		input logic [`DSP_IN_W-1:0] coef,
		input logic [`DSP_BANK_AW-1:0] aa, input logic [`DSP_BANK_AW-1:0] ab
	);
		logic [17:0] c_lo;
		logic [17:0] c_hi;
		logic [26:0] c_wide;
		logic [63:0] p_lo;
		logic [63:0] p_hi;
		logic [73:0] packed_prod;
		logic [63:0] post;
		logic [63:0] negv;
		logic [63:0] fin;
		logic [63:0] ea;
		logic [35:0] eb;
		@(negedge clk);
		check_due();
		c_lo = ia ? bank_a_model[aa] : coef[17:0];
		c_hi = ib ? bank_b_model[ab] : coef[35:18];
		c_wide = ia ? {bank_b_model[ab][8:0], bank_a_model[aa]} : coef[26:0];
		if (m) begin
			p_lo = (64'(in1[25:0]) + 64'(in2[25:0])) * 64'(c_wide);
			p_hi = '0;
			packed_prod = {20'b0, p_lo[53:0]};
			post = p_lo;
		end else begin
			p_lo = (64'(in1[17:0]) + 64'(in2[17:0])) * 64'(c_lo);
			p_hi = (64'(in1[35:18]) + 64'(in2[35:18])) * 64'(c_hi);
			packed_prod = {p_hi[36:0], p_lo[36:0]};
			post = s ? p_lo - p_hi : p_lo + p_hi;
		end
		negv = neg ? -post : post;
		if (acc) fin = negv + model_acc;
		else if (ld) fin = constant;
		else if (neg) fin = negv + chainin;
		else fin = negv;
		if (rsel) begin
			ea = fin;
			eb = '0;
		end else begin
			ea = 64'(packed_prod[35:0]);
			eb = packed_prod[72:37];
		end
		model_acc = ea; // Valid for back-to-back items only
		drive_idle();
		{mode, sub, negate, accumulate, loadconst, result_sel} = {m, s, neg, acc, ld, rsel};
		{internal_coeff_a, internal_coeff_b} = {ia, ib};
		{pre_in1, pre_in2, coef_in} = {in1, in2, coef};
		{coef_addr_a, coef_addr_b} = {aa, ab};
		exp_a_q.push_back(ea);
		exp_b_q.push_back(eb);
		due_q.push_back(cycle_cnt + 5); // Four edges after the capture edge
	endtask

	task automatic write_bank(input logic sel, input logic [`DSP_BANK_AW-1:0] addr,
		input logic [`DSP_HALF_W-1:0] data);
		@(negedge clk);
		check_due();
		drive_idle();
		{bank_we, bank_sel, bank_addr, bank_data} = {1'b1, sel, addr, data};
		if (sel) bank_a_model[addr] = data;
		else bank_b_model[addr] = data;
	endtask

	task automatic drain();
		@(negedge clk);
		check_due();
		drive_idle();
		while (due_q.size() > 0) begin
			@(negedge clk);
			check_due();
		end
	endtask

	task automatic dual_add_sub();
		issue_item(MODE_DUAL, 0, 0, 0, 0, 1, 0, 0, '1, '1, '1, 0, 0); // Largest sum
		issue_item(MODE_DUAL, 1, 0, 0, 0, 1, 0, 0, {18'h3ffff, 18'h0}, '0, '1, 0, 0);
		for (int i = 0; i < N_ADDSUB; i++)
			issue_item(MODE_DUAL, 1'(rand_bits(1)), 0, 0, 0, 1, 0, 0, 36'(rand_bits(36)),
				36'(rand_bits(36)), 36'(rand_bits(36)), 0, 0);
		drain();
	endtask

	task automatic negate_with_chain();
		for (int r = 0; r < 2; r++) begin
			chainin = rand_bits(64); // Held for the whole burst
			for (int i = 0; i < N_CHAIN; i++)
				issue_item(1'(rand_bits(1)), 1'(rand_bits(1)), 1, 0, 0, 1, 0, 0,
					36'(rand_bits(36)), 36'(rand_bits(36)), 36'(rand_bits(36)), 0, 0);
			drain();
		end
	endtask

	task automatic wide_multiply();
		issue_item(MODE_WIDE, 1, 0, 0, 0, 1, 0, 0, '1, '1, '1, 0, 0);
		for (int i = 0; i < N_WIDE; i++)
			issue_item(MODE_WIDE, 1'(rand_bits(1)), 0, 0, 0, 1, 0, 0, 36'(rand_bits(36)),
				36'(rand_bits(36)), 36'(rand_bits(36)), 0, 0);
		drain();
	endtask

	task automatic bank_coefficients();
		for (int a = 0; a < (1 << `DSP_BANK_AW); a++) begin
			write_bank(1, 3'(a), 18'(rand_bits(18)));
			write_bank(0, 3'(a), 18'(rand_bits(18)));
		end
		for (int i = 0; i < N_BANK; i++)
			issue_item(MODE_DUAL, 1'(rand_bits(1)), 0, 0, 0, 1, 1, 1, 36'(rand_bits(36)),
				36'(rand_bits(36)), 36'(rand_bits(36)), 3'(rand_bits(3)), 3'(rand_bits(3)));
		for (int i = 0; i < N_BANK; i++)
			issue_item(MODE_WIDE, 0, 0, 0, 0, 1, 1, 0, 36'(rand_bits(36)),
				36'(rand_bits(36)), 36'(rand_bits(36)), 3'(rand_bits(3)), 3'(rand_bits(3)));
		drain();
	endtask

	// Chain input must lose against both accumulate and loadconst
	task automatic load_then_accumulate();
		constant = rand_bits(64);
		chainin = rand_bits(64);
		issue_item(MODE_DUAL, 0, 1, 0, 1, 1, 0, 0, 36'(rand_bits(36)), 36'(rand_bits(36)),
			36'(rand_bits(36)), 0, 0);
		for (int i = 0; i < N_ACC; i++)
			issue_item(1'(rand_bits(1)), 1'(rand_bits(1)), 1'(rand_bits(1)), 1, 0, 1, 0, 0,
				36'(rand_bits(36)), 36'(rand_bits(36)), 36'(rand_bits(36)), 0, 0);
		drain();
	endtask

	task automatic raw_products();
		for (int i = 0; i < N_RAW; i++)
			issue_item(MODE_DUAL, 1'(rand_bits(1)), 1'(rand_bits(1)), 0, 0, 0, 0, 0,
				36'(rand_bits(36)), 36'(rand_bits(36)), 36'(rand_bits(36)), 0, 0);
		drain();
	endtask

	initial begin
		reset = 1'b1;
		drive_idle();
		chainin = '0;
		constant = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_cnt++;
		if (resulta !== '0) begin
			error_cnt++;
			$display("MISMATCH resulta after reset: got %h expected %h", resulta, 64'h0);
		end
		if (resultb !== '0) begin
			error_cnt++;
			$display("MISMATCH resultb after reset: got %h expected %h", resultb, 36'h0);
		end
		if (chainout !== '0) begin
			error_cnt++;
			$display("MISMATCH chainout after reset: got %h expected %h", chainout, 64'h0);
		end
		dual_add_sub();
		negate_with_chain();
		wide_multiply();
		bank_coefficients();
		load_then_accumulate();
		raw_products();
		$display("Summary: %0d checks, %0d mismatches", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
design/dsp_pkg.sv
design/coeff_bank.sv
design/operand_select.sv
design/dual_multiplier.sv
design/post_accumulate.sv
design/dsp_slice_top.sv
sim/tb_dsp_slice.sv

//--- Makefile
# Verilator build and run for the MAC slice testbench

VERILATOR ?= verilator
TOP       ?= tb_dsp_slice
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
